/* vlog.f */
+incdir+design
design/opm_bus_pkg.sv
design/opm_timer_pkg.sv
design/opm_timinggen.sv
design/opm_busif.sv
design/opm_timer.sv
design/opm_top.sv
bench/tb_opm.sv

/* bench/tb_opm.sv */
`timescale 1ns/10ps

`include "opm_config.svh"

module tb_opm;

    import opm_bus_pkg::*;

    localparam int CLK_HALF   = 20;
    localparam int SAMPLE_CYC = `OPM_SLOTS * 2;

    logic      i_emuclk;
    logic      i_arst_n;
    logic      i_phim_cen_n;
    logic      i_cs_n, i_rd_n, i_wr_n, i_a0;
    opm_data_t i_d;
    opm_data_t o_d;
    logic      o_d_oe, o_phi1, o_ct1, o_ct2, o_irq_n;

    string     dname_q[$];
    opm_data_t dgot_q[$];
    opm_data_t dexp_q[$];
    string     bname_q[$];
    logic      bgot_q[$];
    logic      bexp_q[$];
    logic      oe_seen;
    time       t_data;
    int        limit_cyc;

    opm_top opm_top_inst (
        .i_emuclk     (i_emuclk     ), .i_arst_n (i_arst_n ),
        .i_phim_cen_n (i_phim_cen_n ), .i_cs_n   (i_cs_n   ),
        .i_rd_n       (i_rd_n       ), .i_wr_n   (i_wr_n   ),
        .i_a0         (i_a0         ), .i_d      (i_d      ),
        .o_d          (o_d          ), .o_d_oe   (o_d_oe   ),
        .o_phi1       (o_phi1       ), .o_ct1    (o_ct1    ),
        .o_ct2        (o_ct2        ), .o_irq_n  (o_irq_n  )
    );

    always #CLK_HALF i_emuclk = ~i_emuclk;

    ////////////////////////////////////////
    // reference and checking
    ////////////////////////////////////////

    // expected timer period in emuclk cycles
    function automatic int opm_ref_period(input logic timer_b, input int load);
        int samples;
        if (timer_b) begin
            samples = `OPM_TIMB_PRESCALE * (256 - load);
        end else begin
            samples = 1024 - load;
        end
        return samples * SAMPLE_CYC;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_data(input string name, input opm_data_t got, input opm_data_t exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic expect_data(input string name, input opm_data_t got, input opm_data_t exp);
        dname_q.push_back(name);
        dgot_q.push_back(got);
        dexp_q.push_back(exp);
    endtask

    task automatic expect_bit(input string name, input logic got, input logic exp);
        bname_q.push_back(name);
        bgot_q.push_back(got);
        bexp_q.push_back(exp);
    endtask

    // comparer
    initial begin
        forever begin
            @(negedge i_emuclk);
            while (dname_q.size() > 0) begin
                check_data(dname_q.pop_front(), dgot_q.pop_front(), dexp_q.pop_front());
            end
            while (bname_q.size() > 0) begin
                check_bit(bname_q.pop_front(), bgot_q.pop_front(), bexp_q.pop_front());
            end
        end
    end

    // watchdog armed once the tested periods are known
    initial begin
        wait (limit_cyc > 0);
        repeat (limit_cyc) @(posedge i_emuclk);
        abort_run("timeout: the tests did not finish in the expected number of cycles");
    end

    ////////////////////////////////////////
    // bus tasks
    ////////////////////////////////////////

    task automatic bus_cycle(input logic wr, input logic rd, input logic a0,
                             input opm_data_t d, output opm_data_t q);
        @(posedge i_emuclk);
        #2;
        i_cs_n = ~(wr | rd);
        i_wr_n = ~wr;
        i_rd_n = ~rd;
        i_a0   = a0;
        i_d    = d;
        @(negedge i_emuclk);
        q       = o_d;
        oe_seen = o_d_oe;
    endtask

    task automatic read_status(output opm_data_t q);
        bus_cycle(1'b0, 1'b1, 1'b0, '0, q);
        expect_bit("o_d_oe", oe_seen, 1'b1);
    endtask

    // first status after the write comes back in first
    task automatic wait_ready(output opm_data_t first);
        opm_data_t q;
        int        n;
        n = 0;
        read_status(first);
        q = first;
        while (q[7] && n < 128) begin
            read_status(q);
            n++;
        end
        if (q[7]) begin
            abort_run("busy did not clear within 128 cycles after a data write");
        end
    endtask

    task automatic write_reg(input opm_addr_t addr, input opm_data_t data,
                             output opm_data_t first);
        opm_data_t q;
        bus_cycle(1'b1, 1'b0, 1'b0, addr, q);
        bus_cycle(1'b1, 1'b0, 1'b1, data, q);
        t_data = $time;
        wait_ready(first);
    endtask

    // polls one status flag and times it from the last data write
    task automatic wait_flag(input int idx, input int ref_cyc, input int window,
                             input string name);
        opm_data_t q;
        int        elapsed;
        q       = '0;
        elapsed = 0;
        while (!q[idx] && elapsed <= ref_cyc + window) begin
            read_status(q);
            elapsed = int'(($time - t_data) / (2 * CLK_HALF));
        end
        if (!q[idx]) begin
            abort_run({name, " never set"});
        end else if (elapsed < ref_cyc - window) begin
            abort_run({name, " set too early"});
        end else if (elapsed > ref_cyc + window) begin
            abort_run({name, " set too late"});
        end
        expect_bit("o_irq_n", o_irq_n, 1'b0);
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        opm_data_t st;
        opm_data_t ct;
        int        la, lb, ref_a, ref_b;
        logic      phi1_exp;
        i_emuclk     = 1'b0;
        i_arst_n     = 1'b0;
        i_phim_cen_n = 1'b0;
        i_cs_n       = 1'b1;
        i_rd_n       = 1'b1;
        i_wr_n       = 1'b1;
        i_a0         = 1'b0;
        i_d          = '0;
        void'($urandom(31));
        // loads near the top keep the periods short
        la        = 1024 - 4 - int'($urandom % 8);
        lb        = 256 - 1 - int'($urandom % 2);
        ref_a     = opm_ref_period(1'b0, la);
        ref_b     = opm_ref_period(1'b1, lb);
        limit_cyc = ref_a + 3 * ref_b + 4000;
        repeat (4) @(posedge i_emuclk);
        #2;
        i_arst_n = 1'b1;

        // reset state
        @(negedge i_emuclk);
        expect_bit("o_irq_n", o_irq_n, 1'b1);
        expect_bit("o_ct1", o_ct1, 1'b0);
        expect_bit("o_ct2", o_ct2, 1'b0);
        expect_bit("o_d_oe", o_d_oe, 1'b0);
        phi1_exp = 1'b0;
        expect_bit("o_phi1", o_phi1, phi1_exp);
        // phi1 pin flips on every edge while phiM is enabled each cycle
        repeat (4) begin
            @(negedge i_emuclk);
            phi1_exp = ~phi1_exp;
            expect_bit("o_phi1", o_phi1, phi1_exp);
        end
        read_status(st);
        expect_data("status", st, 8'h00);

        // CT pins
        ct = opm_data_t'($urandom);
        // keep at least one pin away from its reset level
        if (ct[7:6] == 2'b00) begin
            ct[7] = 1'b1;
        end
        write_reg(`OPM_REG_CT, ct, st);
        expect_data("status_busy", st & 8'h80, 8'h80);
        expect_bit("o_ct2", o_ct2, ct[7]);
        expect_bit("o_ct1", o_ct1, ct[6]);

        // timer A
        write_reg(`OPM_REG_CLKA1, opm_data_t'(la >> 2), st);
        write_reg(`OPM_REG_CLKA2, opm_data_t'(la & 3), st);
        write_reg(`OPM_REG_TIMERCTRL, 8'h05, st);
        wait_flag(0, ref_a, SAMPLE_CYC, "timer A flag");
        write_reg(`OPM_REG_TIMERCTRL, 8'h14, st);
        read_status(st);
        expect_data("status", st, 8'h00);
        expect_bit("o_irq_n", o_irq_n, 1'b1);

        // timer B then flag reset
        write_reg(`OPM_REG_CLKB, opm_data_t'(lb), st);
        write_reg(`OPM_REG_TIMERCTRL, 8'h0A, st);
        wait_flag(1, ref_b, 16 * SAMPLE_CYC, "timer B flag");
        write_reg(`OPM_REG_TIMERCTRL, 8'h28, st);
        read_status(st);
        expect_data("status", st, 8'h00);
        expect_bit("o_irq_n", o_irq_n, 1'b1);

        // both running with irq enables clear
        write_reg(`OPM_REG_TIMERCTRL, 8'h03, st);
        for (int i = 0; i < 2 * ref_b; i++) begin
            read_status(st);
            expect_data("status", st, 8'h00);
            expect_bit("o_irq_n", o_irq_n, 1'b1);
        end
        write_reg(`OPM_REG_TIMERCTRL, 8'h00, st);

        // second data write lands while busy
        // new CT bits differ from the ones now on the pins
        ct = (~ct & 8'hC0) | (opm_data_t'($urandom) & 8'h3F);
        bus_cycle(1'b1, 1'b0, 1'b0, `OPM_REG_CT, st);
        bus_cycle(1'b1, 1'b0, 1'b1, ct, st);
        bus_cycle(1'b1, 1'b0, 1'b1, ~ct, st);
        wait_ready(st);
        expect_data("status_busy", st & 8'h80, 8'h80);
        expect_bit("o_ct2", o_ct2, ct[7]);
        expect_bit("o_ct1", o_ct1, ct[6]);

        wait (dname_q.size() == 0 && bname_q.size() == 0);
        @(posedge i_emuclk);
        $display("Simulation passed");
        $finish;
    end

endmodule

/* design/opm_top.sv */
`timescale 1ns/10ps

module opm_top (
    input  logic                    i_emuclk,
    input  logic                    i_arst_n,
    input  logic                    i_phim_cen_n,
    input  logic                    i_cs_n,
    input  logic                    i_rd_n,
    input  logic                    i_wr_n,
    input  logic                    i_a0,
    input  opm_bus_pkg::opm_data_t  i_d,
    output opm_bus_pkg::opm_data_t  o_d,
    output logic                    o_d_oe,
    output logic                    o_phi1,
    output logic                    o_ct1,
    output logic                    o_ct2,
    output logic                    o_irq_n
);

    import opm_timer_pkg::*;

    logic      cycle_31;
    tima_cnt_t clka;
    timb_cnt_t clkb;
    logic      run_a, run_b;
    logic      irqen_a, irqen_b;
    logic      frst_a, frst_b;
    logic      flag_a, flag_b;

    ////////////////////////////////////////
    // blocks
    ////////////////////////////////////////

    // the timers only follow the sample end, phi1 enable has no load here
    opm_timinggen timinggen_inst (
        .i_emuclk     (i_emuclk     ),
        .i_arst_n     (i_arst_n     ),
        .i_phim_cen_n (i_phim_cen_n ),
        .o_phi1       (o_phi1       ),
        .o_phi1_cen   (             ),
        .o_cycle_31   (cycle_31     )
    );

    opm_busif busif_inst (
        .i_emuclk  (i_emuclk ), .i_arst_n  (i_arst_n ),
        .i_cs_n    (i_cs_n   ), .i_wr_n    (i_wr_n   ),
        .i_rd_n    (i_rd_n   ), .i_a0      (i_a0     ),
        .i_d       (i_d      ), .o_d       (o_d      ),
        .o_d_oe    (o_d_oe   ), .i_cycle_31(cycle_31 ),
        .i_flag_a  (flag_a   ), .i_flag_b  (flag_b   ),
        .o_clka    (clka     ), .o_clkb    (clkb     ),
        .o_run_a   (run_a    ), .o_run_b   (run_b    ),
        .o_irqen_a (irqen_a  ), .o_irqen_b (irqen_b  ),
        .o_frst_a  (frst_a   ), .o_frst_b  (frst_b   ),
        .o_ct1     (o_ct1    ), .o_ct2     (o_ct2    )
    );

    opm_timer timer_inst (
        .i_emuclk  (i_emuclk ), .i_arst_n  (i_arst_n ),
        .i_cycle_31(cycle_31 ),
        .i_clka    (clka     ), .i_clkb    (clkb     ),
        .i_run_a   (run_a    ), .i_run_b   (run_b    ),
        .i_irqen_a (irqen_a  ), .i_irqen_b (irqen_b  ),
        .i_frst_a  (frst_a   ), .i_frst_b  (frst_b   ),
        .o_flag_a  (flag_a   ), .o_flag_b  (flag_b   ),
        .o_irq_n   (o_irq_n  )
    );

endmodule

/* design/opm_timer.sv */
`timescale 1ns/10ps

`include "opm_config.svh"

module opm_timer (
    input  logic                      i_emuclk,
    input  logic                      i_arst_n,
    input  logic                      i_cycle_31,
    input  opm_timer_pkg::tima_cnt_t  i_clka,
    input  opm_timer_pkg::timb_cnt_t  i_clkb,
    input  logic                      i_run_a,
    input  logic                      i_run_b,
    input  logic                      i_irqen_a,
    input  logic                      i_irqen_b,
    input  logic                      i_frst_a,
    input  logic                      i_frst_b,
    output logic                      o_flag_a,
    output logic                      o_flag_b,
    output logic                      o_irq_n
);

    import opm_timer_pkg::*;

    localparam timb_pre_t PRE_LAST = timb_pre_t'(`OPM_TIMB_PRESCALE - 1);

    tima_cnt_t cnt_a_q;
    timb_cnt_t cnt_b_q;
    timb_pre_t pre_q;
    logic      tick_b;
    logic      ovf_a;
    logic      ovf_b;

    ////////////////////////////////////////
    // timer B prescaler
    ////////////////////////////////////////

    // free running, independent of run_b
    always_ff @(posedge i_emuclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pre_q <= '0;
        end else if (i_cycle_31) begin
            pre_q <= (pre_q == PRE_LAST) ? timb_pre_t'(0) : pre_q + timb_pre_t'(1);
        end
    end

    assign tick_b = i_cycle_31 & (pre_q == PRE_LAST);

    ////////////////////////////////////////
    // counters
    ////////////////////////////////////////

    assign ovf_a = i_run_a & i_cycle_31 & (&cnt_a_q);
    assign ovf_b = i_run_b & tick_b & (&cnt_b_q);

    always_ff @(posedge i_emuclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt_a_q <= '0;
        end else if (!i_run_a || ovf_a) begin
            cnt_a_q <= i_clka;
        end else if (i_cycle_31) begin
            cnt_a_q <= cnt_a_q + tima_cnt_t'(1);
        end
    end

    always_ff @(posedge i_emuclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt_b_q <= '0;
        end else if (!i_run_b || ovf_b) begin
            cnt_b_q <= i_clkb;
        end else if (tick_b) begin
            cnt_b_q <= cnt_b_q + timb_cnt_t'(1);
        end
    end

    ////////////////////////////////////////
    // flags and interrupt
    ////////////////////////////////////////

    // flag reset wins over a same cycle overflow
    always_ff @(posedge i_emuclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_flag_a <= 1'b0;
            o_flag_b <= 1'b0;
        end else begin
            if (i_frst_a) begin
                o_flag_a <= 1'b0;
            end else if (ovf_a && i_irqen_a) begin
                o_flag_a <= 1'b1;
            end
            if (i_frst_b) begin
                o_flag_b <= 1'b0;
            end else if (ovf_b && i_irqen_b) begin
                o_flag_b <= 1'b1;
            end
        end
    end

    assign o_irq_n = ~((o_flag_a & i_irqen_a) | (o_flag_b & i_irqen_b));

endmodule

/* design/opm_busif.sv */
`timescale 1ns/10ps

`include "opm_config.svh"

module opm_busif (
    input  logic                      i_emuclk,
    input  logic                      i_arst_n,
    input  logic                      i_cs_n,
    input  logic                      i_wr_n,
    input  logic                      i_rd_n,
    input  logic                      i_a0,
    input  opm_bus_pkg::opm_data_t    i_d,
    output opm_bus_pkg::opm_data_t    o_d,
    output logic                      o_d_oe,
    input  logic                      i_cycle_31,
    input  logic                      i_flag_a,
    input  logic                      i_flag_b,
    output opm_timer_pkg::tima_cnt_t  o_clka,
    output opm_timer_pkg::timb_cnt_t  o_clkb,
    output logic                      o_run_a,
    output logic                      o_run_b,
    output logic                      o_irqen_a,
    output logic                      o_irqen_b,
    output logic                      o_frst_a,
    output logic                      o_frst_b,
    output logic                      o_ct1,
    output logic                      o_ct2
);

    import opm_bus_pkg::*;

    localparam logic [1:0] BUSY_LAST = 2'(`OPM_BUSY_SAMPLES - 1);

    opm_addr_t  addr_q;
    bus_state_e state_q;
    logic [1:0] busy_cnt_q;
    logic       busy;
    logic       wr_cyc;
    logic       data_wr;
    opm_data_t  status;

    assign wr_cyc  = ~i_cs_n & ~i_wr_n;
    // data writes are dropped while busy
    assign data_wr = wr_cyc & i_a0 & (state_q == BUS_IDLE);

    ////////////////////////////////////////
    // address latch and registers
    ////////////////////////////////////////

    always_ff @(posedge i_emuclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            addr_q    <= '0;
            o_clka    <= '0;
            o_clkb    <= '0;
            o_run_a   <= 1'b0;
            o_run_b   <= 1'b0;
            o_irqen_a <= 1'b0;
            o_irqen_b <= 1'b0;
            o_frst_a  <= 1'b0;
            o_frst_b  <= 1'b0;
            o_ct1     <= 1'b0;
            o_ct2     <= 1'b0;
        end else begin
            // flag resets are one cycle strobes
            o_frst_a <= 1'b0;
            o_frst_b <= 1'b0;
            if (wr_cyc && !i_a0) begin
                addr_q <= i_d;
            end
            if (data_wr) begin
                case (addr_q)
                    `OPM_REG_CLKA1: o_clka[9:2] <= i_d;
                    `OPM_REG_CLKA2: o_clka[1:0] <= i_d[1:0];
                    `OPM_REG_CLKB:  o_clkb      <= i_d;
                    `OPM_REG_TIMERCTRL: begin
                        o_run_a   <= i_d[0];
                        o_run_b   <= i_d[1];
                        o_irqen_a <= i_d[2];
                        o_irqen_b <= i_d[3];
                        o_frst_a  <= i_d[4];
                        o_frst_b  <= i_d[5];
                    end
                    `OPM_REG_CT: begin
                        o_ct2 <= i_d[7];
                        o_ct1 <= i_d[6];
                    end
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // busy state machine
    ////////////////////////////////////////

    always_ff @(posedge i_emuclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q    <= BUS_IDLE;
            busy_cnt_q <= '0;
        end else begin
            case (state_q)
                BUS_IDLE: if (data_wr) state_q <= BUS_WAIT1;
                // first sample end only aligns to the slot cycle
                BUS_WAIT1: if (i_cycle_31) begin
                    busy_cnt_q <= 2'd1;
                    state_q    <= (BUSY_LAST == 2'd0) ? BUS_IDLE : BUS_WAIT2;
                end
                BUS_WAIT2: if (i_cycle_31) begin
                    if (busy_cnt_q == BUSY_LAST) state_q <= BUS_IDLE;
                    else busy_cnt_q <= busy_cnt_q + 2'd1;
                end
                default: state_q <= BUS_IDLE;
            endcase
        end
    end

    assign busy = (state_q != BUS_IDLE);

    // status readback
    always_comb begin
        status              = '0;
        status[STAT_BUSY]   = busy;
        status[STAT_FLAG_B] = i_flag_b;
        status[STAT_FLAG_A] = i_flag_a;
    end

    assign o_d    = status;
    assign o_d_oe = ~i_cs_n & ~i_rd_n;

endmodule

/* design/opm_timinggen.sv */
`timescale 1ns/10ps

`include "opm_config.svh"

module opm_timinggen (
    input  logic i_emuclk,
    input  logic i_arst_n,
    input  logic i_phim_cen_n,
    output logic o_phi1,
    output logic o_phi1_cen,
    output logic o_cycle_31
);

    import opm_timer_pkg::*;

    localparam slot_t SLOT_LAST = slot_t'(`OPM_SLOTS - 1);

    logic  phim_cen;
    logic  phi1_q;
    logic  phi1_cen;
    slot_t slot_q;

    ////////////////////////////////////////
    // phiM divided by two
    ////////////////////////////////////////

    assign phim_cen = ~i_phim_cen_n;

    always_ff @(posedge i_emuclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            phi1_q <= 1'b0;
        end else if (phim_cen) begin
            phi1_q <= ~phi1_q;
        end
    end

    // every second phiM enable
    assign phi1_cen   = phim_cen & phi1_q;
    assign o_phi1     = phi1_q;
    assign o_phi1_cen = phi1_cen;

    ////////////////////////////////////////
    // slot counter
    ////////////////////////////////////////

    always_ff @(posedge i_emuclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            slot_q <= '0;
        end else if (phi1_cen) begin
            slot_q <= (slot_q == SLOT_LAST) ? slot_t'(0) : slot_q + slot_t'(1);
        end
    end

    // last slot, one emuclk wide
    assign o_cycle_31 = phi1_cen & (slot_q == SLOT_LAST);

endmodule

/* design/opm_timer_pkg.sv */
package opm_timer_pkg;

    // slot position inside one sample
    typedef logic [4:0] slot_t;

    ////////////////////////////////////////
    // timer counters
    ////////////////////////////////////////

    // timer A, 10 bit up-counter and its load value
    typedef logic [9:0] tima_cnt_t;

    // timer B, 8 bit up-counter and its load value
    typedef logic [7:0] timb_cnt_t;

    // timer B sample prescaler
    typedef logic [3:0] timb_pre_t;

endpackage

/* design/opm_bus_pkg.sv */
package opm_bus_pkg;

    // host data bus byte
    typedef logic [7:0] opm_data_t;

    // register address as latched from an a0 low write
    typedef logic [7:0] opm_addr_t;

    // busy handling after a data write
    typedef enum logic [1:0] {
        BUS_IDLE  = 2'd0,
        BUS_WAIT1 = 2'd1,
        BUS_WAIT2 = 2'd2
    } bus_state_e;

    ////////////////////////////////////////
    // status byte layout
    ////////////////////////////////////////

    localparam int STAT_BUSY   = 7;
    localparam int STAT_FLAG_B = 1;
    localparam int STAT_FLAG_A = 0;

endpackage

/* design/opm_config.svh */
`ifndef OPM_CONFIG_SVH
`define OPM_CONFIG_SVH

////////////////////////////////////////
// register map
////////////////////////////////////////

// timer A load, upper 8 bits
`define OPM_REG_CLKA1       8'h10
// timer A load, lower 2 bits
`define OPM_REG_CLKA2       8'h11
`define OPM_REG_CLKB        8'h12
// run, irq enable and flag reset bits
`define OPM_REG_TIMERCTRL   8'h14
// bits 7:6 go to the CT2 and CT1 pins
`define OPM_REG_CT          8'h1B

////////////////////////////////////////
// timing
////////////////////////////////////////

// phi1 cycles per sample
`define OPM_SLOTS           32

// sample ends before busy drops
`define OPM_BUSY_SAMPLES    2

// samples per timer B count
`define OPM_TIMB_PRESCALE   16

`endif
